//--- build.f
source/fmVoicePkg.sv
source/fmBusPkg.sv
source/fmChannelIf.sv
source/fmRegisterFile.sv
source/fmSequencer.sv
source/fmOperatorPipe.sv
source/fmMixer.sv
source/fmSynth.sv
testbench/fmSynthTb.sv

//--- testbench/fmSynthTb.sv
// ==========================================================
// FM tone generator testbench
// Directed tests of the register bus, single tones,
// saturation, phase advance and modulation
// ==========================================================

`timescale 1ns/1ps

module fmSynthTb
	import fmVoicePkg::*;
	import fmBusPkg::*;
();

	localparam int TimeoutCycles = 100;
	localparam logic [31:0] LfsrTaps = 32'h80200003;

	localparam logic [7:0] SineTable [64] = '{
		8'h00, 8'h0C, 8'h18, 8'h24, 8'h30, 8'h3B, 8'h46, 8'h50,
		8'h59, 8'h62, 8'h69, 8'h70, 8'h75, 8'h79, 8'h7C, 8'h7E,
		8'h7F, 8'h7E, 8'h7C, 8'h79, 8'h75, 8'h70, 8'h69, 8'h62,
		8'h59, 8'h50, 8'h46, 8'h3B, 8'h30, 8'h24, 8'h18, 8'h0C,
		8'h00, 8'hF4, 8'hE8, 8'hDC, 8'hD0, 8'hC5, 8'hBA, 8'hB0,
		8'hA7, 8'h9E, 8'h97, 8'h90, 8'h8B, 8'h87, 8'h84, 8'h82,
		8'h81, 8'h82, 8'h84, 8'h87, 8'h8B, 8'h90, 8'h97, 8'h9E,
		8'hA7, 8'hB0, 8'hBA, 8'hC5, 8'hD0, 8'hDC, 8'hE8, 8'hF4
	};

	logic        clock;
	logic        rst;
	logic        busValid;
	logic        busReady;
	logic        busWrite;
	busAddrT     busAddr;
	busDataT     busWriteData;
	logic        respValid;
	logic        respReady;
	busDataT     respData;
	logic        pcmValid;
	sampleT      pcm;
	logic [31:0] lfsrState;
	int          checkCount;
	int          errorCount;
	logic        timedOut;
	// clocks from the last waitPcm call to its pulse
	int          pcmCycles;

	fmSynth i_dut (
		.clock(clock), .rst(rst),
		.busValid(busValid), .busReady(busReady), .busWrite(busWrite),
		.busAddr(busAddr), .busWriteData(busWriteData),
		.respValid(respValid), .respReady(respReady), .respData(respData),
		.pcmValid(pcmValid), .pcm(pcm)
	);

	always #20 clock = ~clock;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		int i;
		value = '0;
		for (i = 0; i < count; i++)
		begin
			value = {value[30:0], lfsrState[0]};
			if (lfsrState[0])
				lfsrState = (lfsrState >> 1) ^ LfsrTaps;
			else
				lfsrState = lfsrState >> 1;
		end
		return value;
	endfunction

	function automatic busAddrT regAddr(input int channel, input regSelT sel);
		return {channelT'(channel), 1'b0, sel};
	endfunction

	function automatic busDataT makeCtrl(input shapeT shape, input int level, input int increment);
		return {shape, levelT'(level), 3'b000, 1'b0, 1'b0, phaseT'(increment)};
	endfunction

	// wave shape then logical right shift by the level
	function automatic logic [7:0] shapeValue(input logic [7:0] raw, input logic [5:0] index,
		input logic [31:0] ctrl);
		logic [7:0] shaped;
		case (ctrl[31:28])
			ShapeHalf:   shaped = raw[7] ? 8'h00 : raw;
			ShapeAbs:    shaped = raw[7] ? ~raw : raw;
			ShapeSquare: shaped = raw[7] ? 8'h80 : 8'h7F;
			ShapeSaw:    shaped = {~index[5], index[4:0], index[4:3]};
			default:     shaped = raw;
		endcase
		return shaped >> ctrl[27:25];
	endfunction

	// model of one channel: modulator, carrier, then mix
	function automatic logic [7:0] channelSample(input logic [31:0] ctrlA, input logic [31:0] ctrlB,
		input logic [19:0] phaseA, input logic [19:0] phaseB);
		logic [5:0] modIndex;
		logic [5:0] carIndex;
		logic [7:0] modValue;
		logic [7:0] carValue;
		modIndex = phaseB[19:14];
		modValue = shapeValue(SineTable[modIndex], modIndex, ctrlB);
		carIndex = phaseA[19:14];
		if (ctrlA[21])
			carIndex = carIndex + modValue[7:2];
		carValue = shapeValue(SineTable[carIndex], carIndex, ctrlA);
		if (ctrlA[21])
			return carValue;
		else
			return carValue + modValue;
	endfunction

	function automatic logic [7:0] saturate(input int sum);
		if (sum > 127)
			return 8'h7F;
		else if (sum < -128)
			return 8'h80;
		else
			return sum[7:0];
	endfunction

	task automatic nextCycle();
		@(posedge clock);
		#1;
	endtask

	task automatic reportTimeout(input string what);
		if (!timedOut)
		begin
			$display("timeout: %s did not go high in %0d cycles", what, TimeoutCycles);
			errorCount++;
		end
		timedOut = 1'b1;
	endtask

	task automatic compare(input string name, input logic [31:0] expected, input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("MISMATCH %s expected %h got %h", name, expected, actual);
		end
	endtask

	task automatic resetDut();
		rst = 1'b1;
		repeat (8) nextCycle();
		rst = 1'b0;
	endtask

	task automatic waitBusReady();
		int count;
		count = 0;
		while (!busReady && !timedOut && count < TimeoutCycles)
		begin
			nextCycle();
			count++;
		end
		if (!busReady)
			reportTimeout("busReady");
	endtask

	task automatic busWriteWord(input busAddrT addr, input busDataT data);
		busValid     = 1'b1;
		busWrite     = 1'b1;
		busAddr      = addr;
		busWriteData = data;
		waitBusReady();
		nextCycle();
		busValid = 1'b0;
		busWrite = 1'b0;
	endtask

	// holdCycles keeps respReady low to stall the response
	task automatic busReadWord(input busAddrT addr, input int holdCycles, output busDataT data);
		int count;
		int i;
		busValid = 1'b1;
		busWrite = 1'b0;
		busAddr  = addr;
		waitBusReady();
		nextCycle();
		busValid = 1'b0;
		count = 0;
		while (!respValid && !timedOut && count < TimeoutCycles)
		begin
			nextCycle();
			count++;
		end
		if (!respValid)
			reportTimeout("respValid");
		data = respData;
		for (i = 0; i < holdCycles; i++)
		begin
			nextCycle();
			compare("respValid", 1, respValid);
			compare("respData", data, respData);
			compare("busReady", 0, busReady);
		end
		respReady = 1'b1;
		nextCycle();
		respReady = 1'b0;
	endtask

	task automatic waitPcm();
		nextCycle();
		pcmCycles = 1;
		while (!pcmValid && !timedOut && pcmCycles < TimeoutCycles)
		begin
			nextCycle();
			pcmCycles++;
		end
		if (!pcmValid)
			reportTimeout("pcmValid");
	endtask

	task automatic reportTest(input string name, input int startErrors);
		$display("%s: done, %0d errors", name, errorCount - startErrors);
	endtask

	task automatic testRegisterAccess();
		int startErrors;
		int i;
		busDataT words [8];
		busDataT data;
		startErrors = errorCount;
		resetDut();
		for (i = 0; i < 4; i++)
		begin
			words[2*i]     = randomBits(32);
			words[2*i + 1] = randomBits(32);
			busWriteWord(regAddr(1 + 4*i, RegCtrlA), words[2*i]);
			busWriteWord(regAddr(1 + 4*i, RegCtrlB), words[2*i + 1]);
		end
		for (i = 0; i < 4; i++)
		begin
			busReadWord(regAddr(1 + 4*i, RegCtrlA), 0, data);
			compare("ctrlA", words[2*i], data);
			busReadWord(regAddr(1 + 4*i, RegCtrlB), 0, data);
			compare("ctrlB", words[2*i + 1], data);
		end
		// reserved bit 2 reads as zero
		busReadWord(regAddr(5, RegCtrlA) | 7'h04, 0, data);
		compare("reserved", 0, data);
		busReadWord(regAddr(5, RegCtrlB) | 7'h04, 0, data);
		compare("reserved", 0, data);
		busWriteWord(regAddr(15, RegPhaseA), 32'h000FFFFF);
		busReadWord(regAddr(15, RegPhaseA), 0, data);
		compare("phaseA", 0, data);
		busReadWord(regAddr(9, RegCtrlB), 5, data);
		compare("ctrlB", words[5], data);
		reportTest("register access", startErrors);
	endtask

	task automatic testSingleTone();
		int startErrors;
		startErrors = errorCount;
		resetDut();
		compare("pcm", 0, $unsigned(pcm));
		compare("pcmValid", 0, pcmValid);
		compare("respValid", 0, respValid);
		compare("busReady", 1, busReady);
		// first pulse on frame cycle 22, then one per frame
		waitPcm();
		compare("pcmValid cycle", 22, pcmCycles);
		compare("pcm", 0, $unsigned(pcm));
		waitPcm();
		compare("pcmValid period", 32, pcmCycles);
		compare("pcm", 0, $unsigned(pcm));
		busWriteWord(regAddr(5, RegCtrlA), makeCtrl(ShapeSquare, 0, 0));
		waitPcm();
		compare("pcm", 8'h7F, $unsigned(pcm));
		waitPcm();
		compare("pcm", 8'h7F, $unsigned(pcm));
		busWriteWord(regAddr(5, RegCtrlA), makeCtrl(ShapeSquare, 2, 0));
		waitPcm();
		compare("pcm", 8'h7F >> 2, $unsigned(pcm));
		busWriteWord(regAddr(5, RegCtrlA), makeCtrl(ShapeSaw, 1, 0));
		waitPcm();
		compare("pcm", 8'h80 >> 1, $unsigned(pcm));
		reportTest("single tone", startErrors);
	endtask

	task automatic testSaturation();
		int startErrors;
		int i;
		startErrors = errorCount;
		resetDut();
		waitPcm();
		for (i = 0; i < 4; i++)
			busWriteWord(regAddr(5*i, RegCtrlA), makeCtrl(ShapeSquare, 0, 0));
		waitPcm();
		compare("pcm", 8'h7F, $unsigned(pcm));
		for (i = 0; i < 4; i++)
			busWriteWord(regAddr(5*i, RegCtrlA), makeCtrl(ShapeSaw, 0, 0));
		waitPcm();
		compare("pcm", 8'h80, $unsigned(pcm));
		reportTest("saturation", startErrors);
	endtask

	task automatic testPhaseAdvance();
		int startErrors;
		int i;
		int pulse;
		phaseT incA [2];
		phaseT incB [2];
		busDataT data;
		startErrors = errorCount;
		resetDut();
		waitPcm();
		// increments written after a pulse apply from the next frame
		for (i = 0; i < 2; i++)
		begin
			incA[i] = phaseT'(randomBits(20));
			incB[i] = phaseT'(randomBits(20));
			busWriteWord(regAddr(2 + 9*i, RegCtrlA), busDataT'(incA[i]));
			busWriteWord(regAddr(2 + 9*i, RegCtrlB), busDataT'(incB[i]));
		end
		for (pulse = 1; pulse <= 3; pulse++)
		begin
			waitPcm();
			for (i = 0; i < 2; i++)
			begin
				busReadWord(regAddr(2 + 9*i, RegPhaseA), 0, data);
				compare("phaseA", phaseT'(pulse * incA[i]), data);
				busReadWord(regAddr(2 + 9*i, RegPhaseB), 0, data);
				compare("phaseB", phaseT'(pulse * incB[i]), data);
			end
		end
		reportTest("phase advance", startErrors);
	endtask

	task automatic testModulation();
		int startErrors;
		int i;
		int frame;
		int sum;
		busDataT ctrlA [3];
		busDataT ctrlB [3];
		logic [7:0] value;
		startErrors = errorCount;
		resetDut();
		waitPcm();
		for (i = 0; i < 3; i++)
		begin
			ctrlA[i] = randomBits(32);
			ctrlB[i] = randomBits(32);
			busWriteWord(regAddr(3 + 4*i, RegCtrlA), ctrlA[i]);
			busWriteWord(regAddr(3 + 4*i, RegCtrlB), ctrlB[i]);
		end
		for (frame = 0; frame < 4; frame++)
		begin
			waitPcm();
			sum = 0;
			for (i = 0; i < 3; i++)
			begin
				value = channelSample(ctrlA[i], ctrlB[i], phaseT'(frame * ctrlA[i][19:0]),
					phaseT'(frame * ctrlB[i][19:0]));
				sum = sum + $signed(value);
			end
			compare("pcm", saturate(sum), $unsigned(pcm));
		end
		reportTest("modulation and mixing", startErrors);
	endtask

	initial
	begin
		clock        = 1'b0;
		rst          = 1'b1;
		busValid     = 1'b0;
		busWrite     = 1'b0;
		busAddr      = '0;
		busWriteData = '0;
		respReady    = 1'b0;
		lfsrState    = 32'd37;
		checkCount   = 0;
		errorCount   = 0;
		timedOut     = 1'b0;
		pcmCycles    = 0;
		if (!timedOut)
			testRegisterAccess();
		if (!timedOut)
			testSingleTone();
		if (!timedOut)
			testSaturation();
		if (!timedOut)
			testPhaseAdvance();
		if (!timedOut)
			testModulation();
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0 && !timedOut)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- source/fmSynth.sv
// ==========================================================
// FM tone generator
// Register bus, channel sequencer, operator pipeline and
// mixer producing one PCM sample per 32-clock frame
// ==========================================================

`timescale 1ns/1ps

module fmSynth
	import fmVoicePkg::*;
	import fmBusPkg::*;
(
	input  logic    clock,
	input  logic    rst,
	input  logic    busValid,
	output logic    busReady,
	input  logic    busWrite,
	input  busAddrT busAddr,
	input  busDataT busWriteData,
	output logic    respValid,
	input  logic    respReady,
	output busDataT respData,
	output logic    pcmValid,
	output sampleT  pcm
);

	channelT  fetchChannel;
	ctrlWordT fetchCtrlA;
	ctrlWordT fetchCtrlB;
	phaseT    fetchPhaseA;
	phaseT    fetchPhaseB;
	logic     phaseWrite;
	channelT  phaseChannel;
	phaseT    newPhaseA;
	phaseT    newPhaseB;
	logic     sampleValid;
	sampleT   sample;
	logic     sampleLast;

	fmChannelIf work ();

	fmRegisterFile i_registerFile (
		.clock(clock), .rst(rst),
		.busValid(busValid), .busReady(busReady), .busWrite(busWrite),
		.busAddr(busAddr), .busWriteData(busWriteData),
		.respValid(respValid), .respReady(respReady), .respData(respData),
		.fetchChannel(fetchChannel),
		.fetchCtrlA(fetchCtrlA), .fetchCtrlB(fetchCtrlB),
		.fetchPhaseA(fetchPhaseA), .fetchPhaseB(fetchPhaseB),
		.phaseWrite(phaseWrite), .phaseChannel(phaseChannel),
		.newPhaseA(newPhaseA), .newPhaseB(newPhaseB)
	);

	fmSequencer i_sequencer (
		.clock(clock), .rst(rst),
		.fetchChannel(fetchChannel),
		.fetchCtrlA(fetchCtrlA), .fetchCtrlB(fetchCtrlB),
		.fetchPhaseA(fetchPhaseA), .fetchPhaseB(fetchPhaseB),
		.phaseWrite(phaseWrite), .phaseChannel(phaseChannel),
		.newPhaseA(newPhaseA), .newPhaseB(newPhaseB),
		.work(work.issue)
	);

	fmOperatorPipe i_operatorPipe (
		.clock(clock), .rst(rst),
		.work(work.accept),
		.sampleValid(sampleValid), .sample(sample), .sampleLast(sampleLast)
	);

	fmMixer i_mixer (
		.clock(clock), .rst(rst),
		.sampleValid(sampleValid), .sample(sample), .sampleLast(sampleLast),
		.pcmValid(pcmValid), .pcm(pcm)
	);

	// sequencer, pipeline and mixer latencies add up to this cycle
	assert property (@(posedge clock) disable iff (rst)
		pcmValid |-> i_sequencer.frameCount == frameT'(PcmValidCycle));

endmodule

//--- source/fmMixer.sv
// ==========================================================
// FM channel mixer
// Sums the channel samples of a frame and outputs the sum
// saturated to one signed 8-bit PCM sample
// ==========================================================

`timescale 1ns/1ps

module fmMixer
	import fmVoicePkg::*;
(
	input  logic   clock,
	input  logic   rst,
	input  logic   sampleValid,
	input  sampleT sample,
	input  logic   sampleLast,
	output logic   pcmValid,
	output sampleT pcm
);

	accumT  accum;
	accumT  sum;
	sampleT clamped;

	assign sum = accum + {{4{sample[7]}}, sample};

	// clamp when the upper bits are not a sign extension
	always_comb
	begin
		if (&sum[11:7] || ~|sum[11:7])
			clamped = sum[7:0];
		else
			clamped = sum[11] ? 8'h80 : 8'h7F;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			accum    <= '0;
			pcmValid <= 1'b0;
			pcm      <= '0;
		end
		else
		begin
			pcmValid <= 1'b0;
			if (sampleValid)
			begin
				if (sampleLast)
				begin
					pcm      <= clamped;
					pcmValid <= 1'b1;
					accum    <= '0;
				end
				else
					accum <= sum;
			end
		end
	end

	// one sample per frame
	assert property (@(posedge clock) disable iff (rst)
		pcmValid |=> !pcmValid [*FrameCycles-1]);

endmodule

//--- source/fmOperatorPipe.sv
// ==========================================================
// FM operator pipeline
// Five stages: modulator lookup and shaping, carrier lookup
// with optional phase modulation, shaping and final mix
// ==========================================================

`timescale 1ns/1ps

module fmOperatorPipe
	import fmVoicePkg::*;
(
	input  logic   clock,
	input  logic   rst,
	fmChannelIf.accept work,
	output logic   sampleValid,
	output sampleT sample,
	output logic   sampleLast
);

	localparam sampleT SineTable [64] = '{
		8'h00, 8'h0C, 8'h18, 8'h24, 8'h30, 8'h3B, 8'h46, 8'h50,
		8'h59, 8'h62, 8'h69, 8'h70, 8'h75, 8'h79, 8'h7C, 8'h7E,
		8'h7F, 8'h7E, 8'h7C, 8'h79, 8'h75, 8'h70, 8'h69, 8'h62,
		8'h59, 8'h50, 8'h46, 8'h3B, 8'h30, 8'h24, 8'h18, 8'h0C,
		8'h00, 8'hF4, 8'hE8, 8'hDC, 8'hD0, 8'hC5, 8'hBA, 8'hB0,
		8'hA7, 8'h9E, 8'h97, 8'h90, 8'h8B, 8'h87, 8'h84, 8'h82,
		8'h81, 8'h82, 8'h84, 8'h87, 8'h8B, 8'h90, 8'h97, 8'h9E,
		8'hA7, 8'hB0, 8'hBA, 8'hC5, 8'hD0, 8'hDC, 8'hE8, 8'hF4
	};

	// shape then level shift, shared by both operators
	function automatic sampleT shapeLevel(sampleT raw, sineIndexT index, ctrlWordT ctrl);
		shapeT  shape;
		sampleT shaped;
		shape = ctrl[ShapeMsb:ShapeLsb];
		case (shape)
			ShapeSine:   shaped = raw;
			ShapeHalf:   shaped = raw[7] ? 8'h00 : raw;
			ShapeAbs:    shaped = raw[7] ? ~raw : raw;
			ShapeSquare: shaped = raw[7] ? 8'h80 : 8'h7F;
			ShapeSaw:    shaped = {~index[5], index[4:0], index[4:3]};
			default:     shaped = raw;
		endcase
		return shaped >> levelT'(ctrl[LevelMsb:LevelLsb]);
	endfunction

	sineIndexT modIndex;
	sineIndexT carIndex;

	logic      s1Valid, s2Valid, s3Valid, s4Valid;
	logic      s1Last, s2Last, s3Last, s4Last;
	ctrlWordT  s1CtrlA, s1CtrlB, s2CtrlA, s3CtrlA;
	phaseT     s1PhaseA, s2PhaseA;
	sineIndexT s1ModIndex, s3CarIndex;
	sampleT    s1ModRaw, s2Mod, s3Mod, s4Mod;
	sampleT    s3CarRaw, s4Car;
	logic      s4ModEn;

	assign modIndex = work.phaseB[19:PhaseIndexLsb];
	// modulator bits 7..2 bend the carrier phase
	assign carIndex = s2PhaseA[19:PhaseIndexLsb]
		+ (s2CtrlA[ModEnBit] ? sineIndexT'(s2Mod[7:2]) : sineIndexT'(0));

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			s1Valid     <= 1'b0;
			s2Valid     <= 1'b0;
			s3Valid     <= 1'b0;
			s4Valid     <= 1'b0;
			sampleValid <= 1'b0;
		end
		else
		begin
			s1Valid     <= work.valid;
			s2Valid     <= s1Valid;
			s3Valid     <= s2Valid;
			s4Valid     <= s3Valid;
			sampleValid <= s4Valid;
		end
	end

	always_ff @(posedge clock)
	begin
		// stage 1, modulator lookup
		s1Last     <= work.last;
		s1CtrlA    <= work.ctrlA;
		s1CtrlB    <= work.ctrlB;
		s1PhaseA   <= work.phaseA;
		s1ModIndex <= modIndex;
		s1ModRaw   <= SineTable[modIndex];
		// stage 2, modulator shape and level
		s2Last     <= s1Last;
		s2CtrlA    <= s1CtrlA;
		s2PhaseA   <= s1PhaseA;
		s2Mod      <= shapeLevel(s1ModRaw, s1ModIndex, s1CtrlB);
		// stage 3, carrier lookup
		s3Last     <= s2Last;
		s3CtrlA    <= s2CtrlA;
		s3Mod      <= s2Mod;
		s3CarIndex <= carIndex;
		s3CarRaw   <= SineTable[carIndex];
		// stage 4, carrier shape and level
		s4Last     <= s3Last;
		s4ModEn    <= s3CtrlA[ModEnBit];
		s4Mod      <= s3Mod;
		s4Car      <= shapeLevel(s3CarRaw, s3CarIndex, s3CtrlA);
		// stage 5, modulator heard only when not modulating
		sampleLast <= s4Last;
		sample     <= s4ModEn ? s4Car : s4Car + s4Mod;
	end

	// valid samples carry known data
	assert property (@(posedge clock) disable iff (rst)
		sampleValid |-> !$isunknown({sample, sampleLast}));

endmodule

//--- source/fmSequencer.sv
// ==========================================================
// FM channel sequencer
// Walks the channels once per frame, advances the phases
// and issues each channel to the operator pipeline
// ==========================================================

`timescale 1ns/1ps

module fmSequencer
	import fmVoicePkg::*;
(
	input  logic     clock,
	input  logic     rst,
	output channelT  fetchChannel,
	input  ctrlWordT fetchCtrlA,
	input  ctrlWordT fetchCtrlB,
	input  phaseT    fetchPhaseA,
	input  phaseT    fetchPhaseB,
	output logic     phaseWrite,
	output channelT  phaseChannel,
	output phaseT    newPhaseA,
	output phaseT    newPhaseB,
	fmChannelIf.issue work
);

	frameT frameCount;
	// frame count of the previous clock, matches the fetched words
	frameT issueCount;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			frameCount <= '0;
			issueCount <= frameT'(FrameCycles - 1);
		end
		else
		begin
			if (frameCount == frameT'(FrameCycles - 1))
				frameCount <= '0;
			else
				frameCount <= frameCount + 1'b1;
			issueCount <= frameCount;
		end
	end

	assign fetchChannel = channelT'(frameCount);

	assign work.valid   = issueCount < frameT'(ChannelCount);
	assign work.channel = channelT'(issueCount);
	assign work.last    = issueCount == frameT'(ChannelCount - 1);
	assign work.ctrlA   = fetchCtrlA;
	assign work.ctrlB   = fetchCtrlB;
	assign work.phaseA  = fetchPhaseA;
	assign work.phaseB  = fetchPhaseB;

	// write-back alongside the issue, wraps mod 2^20
	assign phaseWrite   = work.valid;
	assign phaseChannel = channelT'(issueCount);
	assign newPhaseA    = fetchPhaseA + phaseT'(fetchCtrlA[IncMsb:0]);
	assign newPhaseB    = fetchPhaseB + phaseT'(fetchCtrlB[IncMsb:0]);

	assert property (@(posedge clock) disable iff (rst)
		frameCount > frameT'(ChannelCount) |-> !work.valid);

endmodule

//--- source/fmRegisterFile.sv
// ==========================================================
// FM register file
// Bus slave for the control words and phase accumulators,
// with a fetch port and phase write-back for the sequencer
// ==========================================================

`timescale 1ns/1ps

module fmRegisterFile
	import fmVoicePkg::*;
	import fmBusPkg::*;
(
	input  logic     clock,
	input  logic     rst,
	input  logic     busValid,
	output logic     busReady,
	input  logic     busWrite,
	input  busAddrT  busAddr,
	input  busDataT  busWriteData,
	output logic     respValid,
	input  logic     respReady,
	output busDataT  respData,
	input  channelT  fetchChannel,
	output ctrlWordT fetchCtrlA,
	output ctrlWordT fetchCtrlB,
	output phaseT    fetchPhaseA,
	output phaseT    fetchPhaseB,
	input  logic     phaseWrite,
	input  channelT  phaseChannel,
	input  phaseT    newPhaseA,
	input  phaseT    newPhaseB
);

	ctrlWordT ctrlA [ChannelCount];
	ctrlWordT ctrlB [ChannelCount];
	phaseT    phaseA [ChannelCount];
	phaseT    phaseB [ChannelCount];

	channelT busChannel;
	regSelT  busSel;
	logic    busReserved;
	logic    accept;
	busDataT readData;

	assign busChannel  = busAddr[AddrChannelMsb:AddrChannelLsb];
	assign busSel      = busAddr[AddrSelMsb:0];
	assign busReserved = busAddr[AddrReservedBit];

	// a pending response stalls the request side
	assign busReady = !respValid;
	assign accept   = busValid && busReady;

	always_comb
	begin
		readData = '0;
		if (!busReserved)
		begin
			case (busSel)
				RegCtrlA:  readData = ctrlA[busChannel];
				RegCtrlB:  readData = ctrlB[busChannel];
				RegPhaseA: readData = busDataT'(phaseA[busChannel]);
				RegPhaseB: readData = busDataT'(phaseB[busChannel]);
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < ChannelCount; i++)
			begin
				ctrlA[i]  <= '0;
				ctrlB[i]  <= '0;
				phaseA[i] <= '0;
				phaseB[i] <= '0;
			end
			respValid <= 1'b0;
		end
		else
		begin
			// phase selects and the reserved bit are read only
			if (accept && busWrite && !busReserved)
			begin
				if (busSel == RegCtrlA)
					ctrlA[busChannel] <= busWriteData;
				if (busSel == RegCtrlB)
					ctrlB[busChannel] <= busWriteData;
			end
			if (phaseWrite)
			begin
				phaseA[phaseChannel] <= newPhaseA;
				phaseB[phaseChannel] <= newPhaseB;
			end
			if (accept && !busWrite)
				respValid <= 1'b1;
			else if (respReady)
				respValid <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept && !busWrite)
			respData <= readData;
		fetchCtrlA  <= ctrlA[fetchChannel];
		fetchCtrlB  <= ctrlB[fetchChannel];
		fetchPhaseA <= phaseA[fetchChannel];
		fetchPhaseB <= phaseB[fetchChannel];
	end

	// response is held steady until taken
	assert property (@(posedge clock) disable iff (rst)
		respValid && !respReady |=> respValid && $stable(respData));

endmodule

//--- source/fmChannelIf.sv
// ==========================================================
// FM channel work item
// One channel per clock from the sequencer to the operators
// ==========================================================

`timescale 1ns/1ps

interface fmChannelIf
	import fmVoicePkg::*;
();

	logic     valid;
	channelT  channel;
	logic     last;
	ctrlWordT ctrlA;
	ctrlWordT ctrlB;
	// phases before this frame's advance
	phaseT    phaseA;
	phaseT    phaseB;

	modport issue (output valid, channel, last, ctrlA, ctrlB, phaseA, phaseB);
	modport accept (input valid, channel, last, ctrlA, ctrlB, phaseA, phaseB);

endinterface

//--- source/fmBusPkg.sv
// ==========================================================
// FM register bus definitions
// Word address map and data types of the register bus
// ==========================================================

package fmBusPkg;

	typedef logic [6:0]  busAddrT;
	typedef logic [31:0] busDataT;
	typedef logic [1:0]  regSelT;

	// address fields
	localparam int AddrChannelMsb  = 6;
	localparam int AddrChannelLsb  = 3;
	localparam int AddrReservedBit = 2;
	localparam int AddrSelMsb      = 1;

	localparam regSelT RegCtrlA  = 2'd0;
	localparam regSelT RegCtrlB  = 2'd1;
	localparam regSelT RegPhaseA = 2'd2;
	localparam regSelT RegPhaseB = 2'd3;

endpackage

//--- source/fmVoicePkg.sv
// ==========================================================
// FM voice definitions
// Channel, phase and sample types, wave shape codes and the
// field layout of the per-channel control words
// ==========================================================

package fmVoicePkg;

	// frame timing
	localparam int ChannelCount  = 16;
	localparam int FrameCycles   = 32;
	localparam int PcmValidCycle = 22;

	// control word fields
	localparam int IncMsb        = 19;
	localparam int ModEnBit      = 21;
	localparam int LevelMsb      = 27;
	localparam int LevelLsb      = 25;
	localparam int ShapeMsb      = 31;
	localparam int ShapeLsb      = 28;

	// top phase bits select the sine entry
	localparam int PhaseIndexLsb = 14;

	typedef logic [3:0]         channelT;
	typedef logic [4:0]         frameT;
	typedef logic [19:0]        phaseT;
	typedef logic signed [7:0]  sampleT;
	typedef logic signed [11:0] accumT;
	typedef logic [31:0]        ctrlWordT;
	typedef logic [2:0]         levelT;
	typedef logic [5:0]         sineIndexT;
	typedef logic [3:0]         shapeT;

	localparam shapeT ShapeSine   = 4'd0;
	localparam shapeT ShapeHalf   = 4'd1;
	localparam shapeT ShapeAbs    = 4'd2;
	localparam shapeT ShapeSquare = 4'd6;
	localparam shapeT ShapeSaw    = 4'd7;

endpackage
